//--- common/fprint_pkg.sv
package fprint_pkg;

	// **********************************************************************
	// widths and sizes
	// **********************************************************************
	localparam int TASK_W    = 4;
	localparam int CORE_W    = 4;
	localparam int FPRINT_W  = 32;
	localparam int NUM_TASKS = 16;
	localparam int NUM_PAIRS = NUM_TASKS / 2;
	localparam int PAIR_W    = TASK_W - 1;

	localparam int DIR_DEPTH = 8;                        // also producer start credits
	localparam int DIR_AW    = $clog2(DIR_DEPTH);

	localparam int CMP_CREDITS = 2;                      // comparator input queue
	localparam int CMP_QW      = $clog2(CMP_CREDITS);
	localparam int CMP_CNT_W   = $clog2(CMP_CREDITS + 1);

	// core bus offsets, address bits [3:0]
	localparam logic [3:0] OFS_STATUS  = 4'd0;         // bit 4 set = checkout
	localparam logic [3:0] OFS_FPRINT  = 4'd1;
	localparam logic [3:0] OFS_PAUSE   = 4'd2;
	localparam logic [3:0] OFS_UNPAUSE = 4'd3;

	// csr offset, data [7:4] table entry, [3:0] core
	localparam logic [5:0] OFS_CORE_ASSIGN = 6'd6;

	typedef logic [TASK_W-1:0]    task_id_t;
	typedef logic [CORE_W-1:0]    core_id_t;
	typedef logic [FPRINT_W-1:0]  fprint_t;
	typedef logic [NUM_TASKS-1:0] task_mask_t;

	// one fingerprint in flight between blocks
	typedef struct packed {
		logic     valid;
		task_id_t task_id;
		fprint_t  fprint;
	} fprint_entry_t;

	typedef struct packed {
		logic     valid;
		task_id_t pair_base;                             // even task of the pair
		logic     mismatch;
	} compare_result_t;

	typedef enum logic [1:0] {ST_IDLE, ST_STORE, ST_HOLD} state_reg_state_t;

	typedef enum logic [1:0] {CMP_IDLE, CMP_LOOKUP, CMP_DECIDE} cmp_state_t;

endpackage

//--- task_state/task_state_regs.sv
`timescale 1ns/1ps

module task_state_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        core_write,
	input  logic [7:0]                  core_addr,
	input  fprint_pkg::fprint_t         core_wdata,
	input  logic                        csr_write,
	input  logic [5:0]                  csr_addr,
	input  logic [7:0]                  csr_wdata,
	input  logic                        dir_credit,
	input  fprint_pkg::task_mask_t      clear_ready,
	output logic                        waitrequest,
	output fprint_pkg::task_mask_t      checkout,
	output fprint_pkg::task_mask_t      checkin,
	output fprint_pkg::task_mask_t      pause,
	output fprint_pkg::task_mask_t      fprints_ready,
	output fprint_pkg::fprint_entry_t   push
);

	import fprint_pkg::*;

	state_reg_state_t state;
	logic [7:0]       wr_addr;                 // accepted write, held for classification
	fprint_t          wr_data;
	core_id_t         core_table [NUM_TASKS];
	fprint_entry_t    pend;                    // fingerprint waiting for a credit
	logic [DIR_AW:0]  credits;

	logic     accept;
	logic     in_store;
	core_id_t wr_core;
	task_id_t wr_task;
	logic     owner;
	logic     status_sel;
	logic     pause_sel;
	logic     unpause_sel;
	logic     fprint_sel;
	logic     elig_found;
	task_id_t elig_task;
	logic     push_fire;

	assign waitrequest = (state != ST_IDLE) | pend.valid;
	assign accept      = core_write & ~waitrequest;

	// **********************************************************************
	// write classification, valid in ST_STORE
	// **********************************************************************
	assign in_store = (state == ST_STORE);
	assign wr_core  = wr_addr[7:4];
	assign wr_task  = wr_data[TASK_W-1:0];
	assign owner    = (core_table[wr_task] == wr_core);

	assign status_sel  = in_store & (wr_addr[3:0] == OFS_STATUS) & owner;
	assign pause_sel   = in_store & (wr_addr[3:0] == OFS_PAUSE) & owner;
	assign unpause_sel = in_store & (wr_addr[3:0] == OFS_UNPAUSE) & owner;
	assign fprint_sel  = in_store & (wr_addr[3:0] == OFS_FPRINT) & elig_found;

	// lowest task owned by the writer that is running
	always_comb begin
		elig_found = 1'b0;
		elig_task  = '0;
		for (int i = NUM_TASKS - 1; i >= 0; i--) begin
			if (core_table[i] == wr_core && checkout[i] && !pause[i] && !checkin[i]) begin
				elig_found = 1'b1;
				elig_task  = task_id_t'(i);
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:  if (accept) state <= ST_STORE;
				ST_STORE: state <= ST_HOLD;
				ST_HOLD:  state <= ST_IDLE;
				default:  state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			wr_addr <= core_addr;
			wr_data <= core_wdata;
		end
	end

	// core table, written from the csr port in one cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_TASKS; i++) core_table[i] <= '0;
		end else if (csr_write && csr_addr == OFS_CORE_ASSIGN) begin
			core_table[csr_wdata[7:4]] <= csr_wdata[3:0];
		end
	end

	// **********************************************************************
	// state bits, updated on the edge that leaves ST_STORE
	// **********************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			checkout      <= '0;
			checkin       <= '0;
			pause         <= '0;
			fprints_ready <= '0;
		end else begin
			if (status_sel && wr_data[TASK_W]) checkout[wr_task] <= 1'b1;
			if (status_sel && !wr_data[TASK_W]) begin
				checkin[wr_task]  <= 1'b1;
				checkout[wr_task] <= 1'b0;
			end
			if (pause_sel) pause[wr_task] <= 1'b1;
			if (unpause_sel) pause[wr_task] <= 1'b0;
			fprints_ready <= fprints_ready & ~clear_ready;
			if (fprint_sel) fprints_ready[elig_task] <= 1'b1;   // set wins over clear
		end
	end

	// push only under credit
	always_comb begin
		push       = pend;
		push.valid = pend.valid & (credits != '0);
	end
	assign push_fire = push.valid;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pend    <= '0;
			credits <= (DIR_AW + 1)'(DIR_DEPTH);
		end else begin
			if (push_fire) pend.valid <= 1'b0;
			if (fprint_sel) begin
				pend.valid   <= 1'b1;
				pend.task_id <= elig_task;
				pend.fprint  <= wr_data;
			end
			case ({push_fire, dir_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

//--- fprint_directory/fprint_directory.sv
`timescale 1ns/1ps

module fprint_directory (
	input  logic                        clk,
	input  logic                        reset,
	input  fprint_pkg::fprint_entry_t   push,
	input  logic                        cmp_credit,
	output logic                        dir_credit,
	output fprint_pkg::fprint_entry_t   cmp_entry,
	output logic [3:0]                  occupancy
);

	import fprint_pkg::*;

	// **********************************************************************
	// circular buffer of accepted fingerprints
	// **********************************************************************
	fprint_entry_t        mem [DIR_DEPTH];
	logic [DIR_AW-1:0]    head;                       // next entry to leave
	logic [DIR_AW-1:0]    tail;                       // next free slot
	logic [DIR_AW:0]      count;
	logic [CMP_CNT_W-1:0] cmp_cred;                   // room left in comparator queue

	logic pop;

	assign pop       = (count != '0) & (cmp_cred != '0);
	assign occupancy = count;

	// entry storage
	always_ff @(posedge clk) begin
		if (push.valid) mem[tail] <= push;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (push.valid) tail <= tail + 1'b1;   // wraps at the power-of-two depth
			if (pop) head <= head + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({push.valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// credits toward the comparator
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cmp_cred <= CMP_CNT_W'(CMP_CREDITS);
		end else begin
			case ({pop, cmp_credit})
				2'b10:   cmp_cred <= cmp_cred - 1'b1;
				2'b01:   cmp_cred <= cmp_cred + 1'b1;
				default: cmp_cred <= cmp_cred;
			endcase
		end
	end

	// **********************************************************************
	// output register and producer credit return
	// **********************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cmp_entry  <= '0;
			dir_credit <= 1'b0;
		end else begin
			dir_credit      <= pop;               // one credit per entry sent on
			cmp_entry.valid <= pop;
			if (pop) begin
				cmp_entry.task_id <= mem[head].task_id;
				cmp_entry.fprint  <= mem[head].fprint;
			end
		end
	end

endmodule

//--- hdl/fprint_comparator.sv
`timescale 1ns/1ps

module fprint_comparator (
	input  logic                          clk,
	input  logic                          reset,
	input  fprint_pkg::fprint_entry_t     cmp_entry,
	output logic                          cmp_credit,
	output fprint_pkg::task_mask_t        clear_ready,
	output fprint_pkg::compare_result_t   result
);

	import fprint_pkg::*;

	// input queue, sized by the credits handed to the directory
	fprint_entry_t        q_mem [CMP_CREDITS];
	logic [CMP_QW-1:0]    q_wr;
	logic [CMP_QW-1:0]    q_rd;
	logic [CMP_CNT_W-1:0] q_cnt;

	cmp_state_t state;
	task_id_t   cur_task;
	fprint_t    cur_fprint;

	// one slot per task pair
	logic [NUM_PAIRS-1:0] slot_valid;
	logic [NUM_PAIRS-1:0] slot_odd;               // which task of the pair is stored
	fprint_t              slot_fprint [NUM_PAIRS];

	logic    lk_valid;
	logic    lk_odd;
	fprint_t lk_fprint;

	logic              deq;
	logic [PAIR_W-1:0] pair;
	logic              partner_hit;

	assign deq  = (q_cnt != '0) & ((state == CMP_IDLE) | (state == CMP_DECIDE));
	assign pair = cur_task[TASK_W-1:1];
	assign partner_hit = lk_valid & (lk_odd != cur_task[0]);

	// **********************************************************************
	// payload: queue storage, current entry, slot lookup
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (cmp_entry.valid) q_mem[q_wr] <= cmp_entry;
		if (deq) begin
			cur_task   <= q_mem[q_rd].task_id;
			cur_fprint <= q_mem[q_rd].fprint;
		end
		if (state == CMP_LOOKUP) begin
			lk_valid  <= slot_valid[pair];
			lk_odd    <= slot_odd[pair];
			lk_fprint <= slot_fprint[pair];
		end
		if (state == CMP_DECIDE && !partner_hit) begin
			slot_odd[pair]    <= cur_task[0];   // newer fingerprint replaces older
			slot_fprint[pair] <= cur_fprint;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			q_wr  <= '0;
			q_rd  <= '0;
			q_cnt <= '0;
		end else begin
			if (cmp_entry.valid) q_wr <= q_wr + 1'b1;
			if (deq) q_rd <= q_rd + 1'b1;
			case ({cmp_entry.valid, deq})
				2'b10:   q_cnt <= q_cnt + 1'b1;
				2'b01:   q_cnt <= q_cnt - 1'b1;
				default: q_cnt <= q_cnt;
			endcase
		end
	end

	// **********************************************************************
	// compare machine, lookup then decide
	// **********************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state       <= CMP_IDLE;
			slot_valid  <= '0;
			cmp_credit  <= 1'b0;
			clear_ready <= '0;
			result      <= '0;
		end else begin
			cmp_credit  <= deq;
			clear_ready <= '0;
			result      <= '0;
			case (state)
				CMP_IDLE:   if (deq) state <= CMP_LOOKUP;
				CMP_LOOKUP: state <= CMP_DECIDE;
				CMP_DECIDE: begin
					if (partner_hit) begin
						result.valid     <= 1'b1;
						result.pair_base <= {pair, 1'b0};
						result.mismatch  <= (lk_fprint != cur_fprint);
						clear_ready      <= task_mask_t'(2'b11) << {pair, 1'b0};
						slot_valid[pair] <= 1'b0;
					end else begin
						slot_valid[pair] <= 1'b1;
					end
					state <= deq ? CMP_LOOKUP : CMP_IDLE;   // back to back when queued
				end
				default: state <= CMP_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/fprint_unit_top.sv
`timescale 1ns/1ps

module fprint_unit_top (
	input  logic                          clk,
	input  logic                          reset,
	// core bus
	input  logic                          core_write,
	input  logic [7:0]                    core_addr,
	input  fprint_pkg::fprint_t           core_wdata,
	output logic                          waitrequest,
	// csr port
	input  logic                          csr_write,
	input  logic [5:0]                    csr_addr,
	input  logic [7:0]                    csr_wdata,
	// status and results
	output fprint_pkg::task_mask_t        checkout,
	output fprint_pkg::task_mask_t        checkin,
	output fprint_pkg::task_mask_t        pause,
	output fprint_pkg::task_mask_t        fprints_ready,
	output logic [3:0]                    occupancy,
	output fprint_pkg::compare_result_t   result
);

	import fprint_pkg::*;

	fprint_entry_t push;          // producer to directory
	logic          dir_credit;
	fprint_entry_t cmp_entry;     // directory to comparator
	logic          cmp_credit;
	task_mask_t    clear_ready;   // finished pairs

	task_state_regs i_task_state_regs (
		.clk           (clk),
		.reset         (reset),
		.core_write    (core_write),
		.core_addr     (core_addr),
		.core_wdata    (core_wdata),
		.csr_write     (csr_write),
		.csr_addr      (csr_addr),
		.csr_wdata     (csr_wdata),
		.dir_credit    (dir_credit),
		.clear_ready   (clear_ready),
		.waitrequest   (waitrequest),
		.checkout      (checkout),
		.checkin       (checkin),
		.pause         (pause),
		.fprints_ready (fprints_ready),
		.push          (push)
	);

	fprint_directory i_fprint_directory (
		.clk        (clk),
		.reset      (reset),
		.push       (push),
		.cmp_credit (cmp_credit),
		.dir_credit (dir_credit),
		.cmp_entry  (cmp_entry),
		.occupancy  (occupancy)
	);

	fprint_comparator i_fprint_comparator (
		.clk         (clk),
		.reset       (reset),
		.cmp_entry   (cmp_entry),
		.cmp_credit  (cmp_credit),
		.clear_ready (clear_ready),
		.result      (result)
	);

endmodule

//--- testbench/fprint_unit_tests.svh
// **********************************************************************
// directed tests
// **********************************************************************
task automatic owner_write(input core_id_t core, input logic [3:0] ofs, input fprint_t data);
	bus_write(core, ofs, data);
	check_state();
endtask

// a write from a core that does not own the task changes nothing
task automatic foreign_write(input core_id_t core, input logic [3:0] ofs, input fprint_t data);
	task_mask_t co;
	task_mask_t ci;
	task_mask_t pa;
	co = checkout;
	ci = checkin;
	pa = pause;
	bus_write(core, ofs, data);
	check_mask("checkout unchanged", co, checkout);
	check_mask("checkin unchanged", ci, checkin);
	check_mask("pause unchanged", pa, pause);
	check_state();
endtask

task automatic test_ownership();
	test_name = "ownership";
	csr_assign(4'd0, 4'd1);
	csr_assign(4'd1, 4'd2);
	owner_write(4'd1, OFS_STATUS, 32'h10);        // checkout task 0
	owner_write(4'd2, OFS_STATUS, 32'h11);
	owner_write(4'd2, OFS_PAUSE, 32'h01);
	foreign_write(4'd2, OFS_STATUS, 32'h00);
	foreign_write(4'd2, OFS_PAUSE, 32'h00);
	foreign_write(4'd1, OFS_UNPAUSE, 32'h01);
	foreign_write(4'd7, OFS_STATUS, 32'h01);
	owner_write(4'd2, OFS_UNPAUSE, 32'h01);
	owner_write(4'd1, OFS_STATUS, 32'h00);        // checkin drops checkout
endtask

task automatic test_pair_match();
	fprint_t fp;
	int      rcv0;
	test_name = "pair_match";
	csr_assign(4'd2, 4'd4);
	csr_assign(4'd3, 4'd5);
	owner_write(4'd4, OFS_STATUS, 32'h12);
	owner_write(4'd5, OFS_STATUS, 32'h13);
	fp   = $random(seed);
	rcv0 = res_count;
	bus_write(4'd4, OFS_FPRINT, fp);
	wait_results();
	check_ready();                                // task 2 waits for its partner
	bus_write(4'd5, OFS_FPRINT, fp);
	wait_results();
	check_int("results", 1, res_count - rcv0);
	check_ready();
endtask

task automatic test_pair_collision();
	fprint_t a;
	fprint_t b;
	fprint_t c;
	test_name = "pair_collision";
	csr_assign(4'd4, 4'd6);
	csr_assign(4'd5, 4'd7);
	owner_write(4'd6, OFS_STATUS, 32'h14);
	owner_write(4'd7, OFS_STATUS, 32'h15);
	a = $random(seed);
	b = $random(seed);
	c = $random(seed);
	if (b == c) c = ~b;
	bus_write(4'd6, OFS_FPRINT, a);
	bus_write(4'd6, OFS_FPRINT, b);               // replaces a
	bus_write(4'd7, OFS_FPRINT, c);
	wait_results();
	// later value equal to the partner gives a match
	bus_write(4'd6, OFS_FPRINT, a);
	bus_write(4'd6, OFS_FPRINT, c);
	bus_write(4'd7, OFS_FPRINT, c);
	wait_results();
	check_ready();
endtask

task automatic test_eligibility();
	fprint_t fp;
	int      busy0;
	test_name = "eligibility";
	csr_assign(4'd8, 4'd8);
	csr_assign(4'd9, 4'd11);
	csr_assign(4'd10, 4'd9);
	csr_assign(4'd12, 4'd10);
	owner_write(4'd8, OFS_STATUS, 32'h18);
	owner_write(4'd8, OFS_PAUSE, 32'h08);         // paused
	owner_write(4'd9, OFS_STATUS, 32'h1a);
	owner_write(4'd9, OFS_STATUS, 32'h0a);        // checked in
	owner_write(4'd11, OFS_STATUS, 32'h19);
	fp    = $random(seed);
	busy0 = occ_busy;
	bus_write(4'd8, OFS_FPRINT, fp);
	bus_write(4'd9, OFS_FPRINT, fp);
	bus_write(4'd10, OFS_FPRINT, fp);             // task 12 never checked out
	wait_results();
	check_int("busy directory cycles", busy0, occ_busy);
	check_ready();
	owner_write(4'd8, OFS_UNPAUSE, 32'h08);
	bus_write(4'd8, OFS_FPRINT, fp);
	bus_write(4'd11, OFS_FPRINT, fp ^ 32'h1);
	wait_results();
	check_ready();
endtask

task automatic test_backpressure();
	int      base [4] = '{2, 4, 6, 14};
	fprint_t fp [4];
	int      k;
	int      t;
	int      rcv0;
	int      stalls0;
	test_name = "backpressure";
	csr_assign(4'd6, 4'd12);
	csr_assign(4'd7, 4'd13);
	csr_assign(4'd14, 4'd14);
	csr_assign(4'd15, 4'd15);
	owner_write(4'd12, OFS_STATUS, 32'h16);
	owner_write(4'd13, OFS_STATUS, 32'h17);
	owner_write(4'd14, OFS_STATUS, 32'h1e);
	owner_write(4'd15, OFS_STATUS, 32'h1f);
	rcv0    = res_count;
	stalls0 = stalls;
	for (int i = 0; i < 12; i++) begin
		k = (i < 8) ? i % 4 : i % 2;
		t = base[k] + (((i >= 4 && i < 8) || i >= 10) ? 1 : 0);
		if (t % 2 == 0) fp[k] = $random(seed);
		bus_write(m_table[t], OFS_FPRINT, (t % 2 == 1 && k % 2 == 1) ? ~fp[k] : fp[k]);
	end
	wait_results();
	check_int("results", 6, res_count - rcv0);
	// store and hold per write, the comparator drains faster than the bus fills
	check_int("waitrequest cycles", 2 * 12, stalls - stalls0);
	check_ready();
endtask

//--- testbench/fprint_unit_tb.sv
`timescale 1ns/1ps

module fprint_unit_tb;

	import fprint_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;   // up to 40 writes per test at about 12 cycles each

	logic            clk = 1'b0;
	logic            reset;
	logic            core_write;
	logic [7:0]      core_addr;
	fprint_t         core_wdata;
	logic            waitrequest;
	logic            csr_write;
	logic [5:0]      csr_addr;
	logic [7:0]      csr_wdata;
	task_mask_t      checkout;
	task_mask_t      checkin;
	task_mask_t      pause;
	task_mask_t      fprints_ready;
	logic [3:0]      occupancy;
	compare_result_t result;

	// reference model
	core_id_t             m_table [NUM_TASKS];
	task_mask_t           m_checkout;
	task_mask_t           m_checkin;
	task_mask_t           m_pause;
	task_mask_t           m_ready;
	logic [NUM_PAIRS-1:0] m_slot_valid;
	logic [NUM_PAIRS-1:0] m_slot_odd;
	fprint_t              m_slot_fp [NUM_PAIRS];
	compare_result_t      exp_q [$];      // results in arrival order

	string  test_name = "reset";
	integer seed = 32'hc0e2_dea7;
	int     cycles = 0;
	int     errors = 0;
	int     checks = 0;
	int     mon_errors = 0;
	int     mon_checks = 0;
	int     rcv_count = 0;
	int     res_count = 0;                // every result the DUT reports
	int     occ_busy = 0;                 // cycles with a non-empty directory
	int     stalls = 0;                   // waitrequest cycles seen by the bus driver

	always #2 clk = ~clk;

	always @(posedge clk) cycles <= cycles + 1;

	fprint_unit_top i_fprint_unit_top (.*);

	// **********************************************************************
	// model of the state registers and the pair comparator
	// **********************************************************************
	task automatic model_fprint(input core_id_t core, input fprint_t data);
		compare_result_t   r;
		logic [PAIR_W-1:0] p;
		for (int i = 0; i < NUM_TASKS; i++) begin
			if (m_table[i] == core && m_checkout[i] && !m_pause[i] && !m_checkin[i]) begin
				p = PAIR_W'(i / 2);
				m_ready[i] = 1'b1;
				if (m_slot_valid[p] && m_slot_odd[p] != i[0]) begin
					r.valid     = 1'b1;
					r.pair_base = task_id_t'(i - i % 2);
					r.mismatch  = (m_slot_fp[p] != data);
					exp_q.push_back(r);
					m_slot_valid[p] = 1'b0;
					m_ready[i]      = 1'b0;   // finished pair
					m_ready[i ^ 1]  = 1'b0;
				end else begin
					m_slot_valid[p] = 1'b1;
					m_slot_odd[p]   = i[0];
					m_slot_fp[p]    = data;
				end
				break;
			end
		end
	endtask

	task automatic model_write(input core_id_t core, input logic [3:0] ofs, input fprint_t data);
		task_id_t t;
		logic     own;
		t   = data[TASK_W-1:0];
		own = (m_table[t] == core);
		if (ofs == OFS_STATUS && own) begin
			m_checkout[t] = data[4];
			m_checkin[t]  = m_checkin[t] | ~data[4];
		end
		if (ofs == OFS_PAUSE && own) m_pause[t] = 1'b1;
		if (ofs == OFS_UNPAUSE && own) m_pause[t] = 1'b0;
		if (ofs == OFS_FPRINT) model_fprint(core, data);
	endtask

	// **********************************************************************
	// bus drivers and checks
	// **********************************************************************
	task automatic bus_write(input core_id_t core, input logic [3:0] ofs, input fprint_t data);
		@(posedge clk);
		core_write <= 1'b1;
		core_addr  <= {core, ofs};
		core_wdata <= data;
		@(negedge clk);
		while (waitrequest) begin
			stalls++;
			@(negedge clk);
		end
		@(posedge clk);                       // accepted on this edge
		core_write <= 1'b0;
		model_write(core, ofs, data);
		@(negedge clk);
		while (waitrequest) begin
			stalls++;
			@(negedge clk);
		end
	endtask

	task automatic csr_assign(input task_id_t t, input core_id_t core);
		@(posedge clk);
		csr_write <= 1'b1;
		csr_addr  <= OFS_CORE_ASSIGN;
		csr_wdata <= {t, core};
		@(posedge clk);
		csr_write <= 1'b0;
		m_table[t] = core;
	endtask

	task automatic check_mask(input string what, input task_mask_t exp, input task_mask_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_int(input string what, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_state();
		check_mask("checkout", m_checkout, checkout);
		check_mask("checkin", m_checkin, checkin);
		check_mask("pause", m_pause, pause);
	endtask

	task automatic check_ready();
		check_mask("fprints_ready", m_ready, fprints_ready);
	endtask

	// drain the pipeline and leave time for clear_ready and stray results
	task automatic wait_results();
		while (rcv_count < exp_q.size()) @(negedge clk);
		repeat (10) @(negedge clk);
	endtask

	`include "fprint_unit_tests.svh"

	// result monitor on the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (int'(occupancy) > DIR_DEPTH) begin
				mon_errors++;
				$display("directory occupancy %0d above its depth in %s",
					occupancy, test_name);
			end
			if (occupancy != '0) occ_busy++;
			if (result.valid) res_count++;
			if (result.valid && rcv_count >= exp_q.size()) begin
				mon_errors++;
				$display("unexpected result for pair %0d in %s", result.pair_base, test_name);
			end else if (result.valid) begin
				mon_checks++;
				if (result.pair_base !== exp_q[rcv_count].pair_base
						|| result.mismatch !== exp_q[rcv_count].mismatch) begin
					mon_errors++;
					$display("FAIL %s pair/mismatch: expected %0d/%0b, actual %0d/%0b",
						test_name, exp_q[rcv_count].pair_base, exp_q[rcv_count].mismatch,
						result.pair_base, result.mismatch);
				end
				rcv_count++;
			end
		end
	end

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("run stopped after %0d cycles in %s, the DUT stopped responding",
			cycles, test_name);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		reset      <= 1'b1;
		core_write <= 1'b0;
		core_addr  <= '0;
		core_wdata <= '0;
		csr_write  <= 1'b0;
		csr_addr   <= '0;
		csr_wdata  <= '0;
		for (int i = 0; i < NUM_TASKS; i++) m_table[i] = '0;
		m_checkout   = '0;
		m_checkin    = '0;
		m_pause      = '0;
		m_ready      = '0;
		m_slot_valid = '0;
		m_slot_odd   = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (waitrequest || result.valid) begin
			errors++;
			$display("waitrequest or result.valid is high after reset");
		end
		test_ownership();
		test_pair_match();
		test_pair_collision();
		test_eligibility();
		test_backpressure();
		$display("errors: %0d in %0d checks", errors + mon_errors, checks + mon_checks);
		if (errors + mon_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- fprint_unit_top.f
+incdir+testbench
common/fprint_pkg.sv
task_state/task_state_regs.sv
fprint_directory/fprint_directory.sv
hdl/fprint_comparator.sv
hdl/fprint_unit_top.sv
testbench/fprint_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fingerprint unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module fprint_unit_tb -f fprint_unit_top.f \
	&& ./obj_dir/Vfprint_unit_tb | tee /dev/stderr | grep -x "TESTBENCH PASSED" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation not ok"; exit 1; }
